//--- design/wb_pkg.sv
package wb_pkg;

   // ------------------------------------------------------------
   // bus widths
   // ------------------------------------------------------------
   localparam int WB_ADR_W = 32;
   localparam int WB_DAT_W = 32;
   localparam int WB_SEL_W = WB_DAT_W / 8;   // one select per byte lane

   // ------------------------------------------------------------
   // request and response bundles
   // ------------------------------------------------------------

   // stb is always equal to cyc on this bus so it is not carried
   typedef struct packed {
      logic [WB_ADR_W-1:0] adr;
      logic [WB_DAT_W-1:0] dat;
      logic [WB_SEL_W-1:0] sel;
      logic                we;
      logic                cyc;
   } wb_req_t;

   typedef struct packed {
      logic [WB_DAT_W-1:0] rdt;
      logic                ack;   // single cycle, ends the bus cycle
   } wb_rsp_t;

endpackage

//--- design/lsu_pkg.sv
package lsu_pkg;

   // ------------------------------------------------------------
   // sizes
   // ------------------------------------------------------------
   localparam int XLEN      = 32;                  // serial steps per phase
   localparam int RAM_WORDS = 256;
   localparam int RAM_AW    = $clog2(RAM_WORDS);   // word address bits

   // ------------------------------------------------------------
   // access width, funct3 encoding of loads
   // ------------------------------------------------------------

   // stores reuse MW_LB, MW_LH and MW_LW for byte, half and word
   typedef enum logic [2:0] {
      MW_LB  = 3'b000,
      MW_LH  = 3'b001,
      MW_LW  = 3'b010,
      MW_LBU = 3'b100,
      MW_LHU = 3'b101
   } mem_width_e;

   // ------------------------------------------------------------
   // instruction fetch FSM
   // ------------------------------------------------------------
   typedef enum logic {
      FS_IDLE = 1'b0,
      FS_BUS  = 1'b1
   } fetch_state_e;

endpackage

//--- design/serial_lsu.sv
`timescale 1ns/1ps

module serial_lsu
   import wb_pkg::*;
   import lsu_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset,
   input  logic       i_en,
   input  logic       i_init,
   input  logic       i_dat_valid,
   input  logic       i_cmd,
   input  mem_width_e i_funct3,
   input  logic       i_rs1,
   input  logic       i_rs2,
   input  logic       i_imm,
   input  logic       i_trap,
   output logic       o_rd,
   output logic       o_misalign,
   output wb_req_t    o_dbus_req,
   input  wb_rsp_t    i_dbus_rsp
);

   logic                is_word;
   logic                is_half;
   logic                is_byte;
   logic                is_signed;
   logic                init_r;
   logic                init_2r;
   logic                carry_r;
   logic                adr_bit;
   logic [XLEN-1:0]     adr_r;
   logic [XLEN-1:0]     dat_r;
   logic [1:0]          bytepos;
   logic [1:0]          misalign_r;
   logic                signbit_r;
   logic                cyc_r;
   logic                bus_ack;
   logic [WB_SEL_W-1:0] sel;
   logic [WB_DAT_W-1:0] wdat;

   assign is_word   = (i_funct3 == MW_LW);
   assign is_half   = (i_funct3 == MW_LH) || (i_funct3 == MW_LHU);
   assign is_byte   = !is_word && !is_half;
   assign is_signed = (i_funct3 == MW_LB) || (i_funct3 == MW_LH) || (i_funct3 == MW_LW);

   // ------------------------------------------------------------
   // address: rs1 + imm, one bit per step
   // ------------------------------------------------------------
   assign adr_bit = i_rs1 ^ i_imm ^ carry_r;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         carry_r <= 1'b0;
         init_r  <= 1'b0;
         init_2r <= 1'b0;
      end else begin
         // carry only lives inside the init phase
         carry_r <= i_init & ((i_rs1 & i_imm) | (carry_r & (i_rs1 ^ i_imm)));
         init_r  <= i_init;
         init_2r <= init_r;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_init)
         adr_r <= {adr_bit, adr_r[XLEN-1:1]};   // LSB enters first, ends up at bit 0
   end

   assign bytepos = adr_r[1:0];   // stable once init is over

   // the two low address bits are seen on the first two init steps
   always_ff @(posedge i_clk) begin
      if (i_reset || !i_en) begin
         misalign_r <= 2'b00;
      end else begin
         if (i_init && !init_r)
            misalign_r[0] <= !is_byte & adr_bit;
         if (init_r && !init_2r)
            misalign_r[1] <= is_word & adr_bit;
      end
   end

   assign o_misalign = |misalign_r;

   // ------------------------------------------------------------
   // data shift register, shared by store and load
   // ------------------------------------------------------------
   assign bus_ack = cyc_r & i_dbus_rsp.ack;

   always_ff @(posedge i_clk) begin
      if (bus_ack && !i_cmd)
         dat_r <= i_dbus_rsp.rdt >> {bytepos, 3'b000};   // selected lanes down to bit 0
      else if (i_en)
         dat_r <= {i_rs2, dat_r[XLEN-1:1]};
      if (i_dat_valid)
         signbit_r <= dat_r[0];   // last real bit is the sign for narrow loads
   end

   assign o_rd = i_dat_valid ? dat_r[0] : (signbit_r & is_signed);

   // store data is copied into every lane so sel alone picks the target
   always_comb begin
      if (is_word)
         wdat = dat_r;
      else if (is_half)
         wdat = {2{dat_r[15:0]}};
      else
         wdat = {4{dat_r[7:0]}};
   end

   always_comb begin
      if (is_word)
         sel = 4'b1111;
      else if (is_half)
         sel = bytepos[1] ? 4'b1100 : 4'b0011;
      else
         sel = 4'b0001 << bytepos;
   end

   // ------------------------------------------------------------
   // bus cycle
   // ------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_reset)
         cyc_r <= 1'b0;
      else if (bus_ack)
         cyc_r <= 1'b0;
      else if (init_r && !i_init && !i_trap)
         cyc_r <= 1'b1;   // second cycle after init falls
   end

   always_comb begin
      o_dbus_req.adr = adr_r;
      o_dbus_req.dat = wdat;
      o_dbus_req.sel = sel;
      o_dbus_req.we  = i_cmd;
      o_dbus_req.cyc = cyc_r;
   end

   // the core has to trap before the bus sees a misaligned access
   ap_no_cyc_on_trap: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(cyc_r) |-> !$past(o_misalign) && !$past(i_trap))
      else $error("[ERROR] serial_lsu: cycle opened adr=%h misalign=%h trap=%h",
                  adr_r, $past(o_misalign), $past(i_trap));

   ap_sel_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
      cyc_r |-> sel != '0)
      else $error("[ERROR] serial_lsu: empty select adr=%h funct3=%h", adr_r, i_funct3);

endmodule

//--- design/insn_fetch.sv
`timescale 1ns/1ps

module insn_fetch
   import wb_pkg::*;
   import lsu_pkg::*;
(
   input  logic                i_clk,
   input  logic                i_reset,
   input  logic                i_fetch,
   input  logic [WB_ADR_W-1:0] i_pc,
   output logic [WB_DAT_W-1:0] o_insn,
   output logic                o_insn_valid,
   output wb_req_t             o_ibus_req,
   input  wb_rsp_t             i_ibus_rsp
);

   fetch_state_e        state_r;
   logic [WB_ADR_W-1:0] pc_r;
   logic [WB_DAT_W-1:0] insn_r;
   logic                valid_r;
   logic                start;
   logic                done;

   assign start = (state_r == FS_IDLE) && i_fetch;   // strobes while busy are dropped
   assign done  = (state_r == FS_BUS) && i_ibus_rsp.ack;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state_r <= FS_IDLE;
         valid_r <= 1'b0;
      end else begin
         valid_r <= done;
         if (start)
            state_r <= FS_BUS;
         else if (done)
            state_r <= FS_IDLE;
      end
   end

   always_ff @(posedge i_clk) begin
      if (start)
         pc_r <= i_pc;
      if (done)
         insn_r <= i_ibus_rsp.rdt;
   end

   assign o_insn       = insn_r;
   assign o_insn_valid = valid_r;

   // word reads only
   always_comb begin
      o_ibus_req.adr = pc_r;
      o_ibus_req.dat = '0;
      o_ibus_req.sel = '1;
      o_ibus_req.we  = 1'b0;
      o_ibus_req.cyc = (state_r == FS_BUS);
   end

   ap_word_read: assert property (@(posedge i_clk) disable iff (i_reset)
      o_ibus_req.cyc |-> (o_ibus_req.sel == '1) && !o_ibus_req.we)
      else $error("[ERROR] insn_fetch: bad request sel=%h we=%h",
                  o_ibus_req.sel, o_ibus_req.we);

endmodule

//--- design/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter
   import wb_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  wb_req_t i_dbus_req,
   output wb_rsp_t o_dbus_rsp,
   input  wb_req_t i_ibus_req,
   output wb_rsp_t o_ibus_rsp,
   output wb_req_t o_mem_req,
   input  wb_rsp_t i_mem_rsp
);

   logic gnt_i;      // instruction port owns the slave this cycle
   logic hold_r;     // a granted cycle was running last cycle
   logic hold_i_r;   // and it belonged to the instruction port
   logic held_cyc;

   // ------------------------------------------------------------
   // grant
   // ------------------------------------------------------------
   assign held_cyc = hold_i_r ? i_ibus_req.cyc : i_dbus_req.cyc;

   always_comb begin
      if (hold_r && held_cyc)
         gnt_i = hold_i_r;
      else
         gnt_i = !i_dbus_req.cyc && i_ibus_req.cyc;   // data port wins a tie
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         hold_r   <= 1'b0;
         hold_i_r <= 1'b0;
      end else begin
         hold_r   <= o_mem_req.cyc;
         hold_i_r <= gnt_i;
      end
   end

   // ------------------------------------------------------------
   // request mux and ack steering
   // ------------------------------------------------------------
   assign o_mem_req = gnt_i ? i_ibus_req : i_dbus_req;

   always_comb begin
      o_dbus_rsp.rdt = i_mem_rsp.rdt;
      o_dbus_rsp.ack = i_mem_rsp.ack & !gnt_i;
      o_ibus_rsp.rdt = i_mem_rsp.rdt;
      o_ibus_rsp.ack = i_mem_rsp.ack & gnt_i;
   end

   // an ack must answer a request that held the grant one cycle earlier
   ap_dbus_ack_granted: assert property (@(posedge i_clk) disable iff (i_reset)
      o_dbus_rsp.ack |-> i_dbus_req.cyc && $past(!gnt_i && i_dbus_req.cyc))
      else $error("[ERROR] wb_arbiter: data ack without grant adr=%h", i_dbus_req.adr);

   ap_ibus_ack_granted: assert property (@(posedge i_clk) disable iff (i_reset)
      o_ibus_rsp.ack |-> i_ibus_req.cyc && $past(gnt_i && i_ibus_req.cyc))
      else $error("[ERROR] wb_arbiter: insn ack without grant adr=%h", i_ibus_req.adr);

endmodule

//--- design/wb_ram.sv
`timescale 1ns/1ps

module wb_ram
   import wb_pkg::*;
   import lsu_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  wb_req_t i_req,
   output wb_rsp_t o_rsp
);

   logic [WB_DAT_W-1:0] mem_r [RAM_WORDS];
   logic [RAM_AW-1:0]   widx;
   logic [WB_DAT_W-1:0] rdt_r;
   logic                ack_r;
   logic                access;

   assign widx   = i_req.adr[RAM_AW+1:2];   // byte address to word index
   assign access = i_req.cyc & !ack_r;      // a held cycle is served once

   always_ff @(posedge i_clk) begin
      if (i_reset)
         ack_r <= 1'b0;
      else
         ack_r <= access;
   end

   // ------------------------------------------------------------
   // storage
   // ------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (access) begin
         rdt_r <= mem_r[widx];
         if (i_req.we) begin
            for (int b = 0; b < WB_SEL_W; b++) begin
               if (i_req.sel[b])
                  mem_r[widx][8*b +: 8] <= i_req.dat[8*b +: 8];
            end
         end
      end
   end

   always_comb begin
      o_rsp.rdt = rdt_r;
      o_rsp.ack = ack_r;
   end

endmodule

//--- design/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
   import wb_pkg::*;
   import lsu_pkg::*;
(
   input  logic                i_clk,
   input  logic                i_reset,
   // serial core side of the load/store unit
   input  logic                i_en,
   input  logic                i_init,
   input  logic                i_dat_valid,
   input  logic                i_cmd,
   input  mem_width_e          i_funct3,
   input  logic                i_rs1,
   input  logic                i_rs2,
   input  logic                i_imm,
   input  logic                i_trap,
   output logic                o_rd,
   output logic                o_misalign,
   output logic                o_ls_done,
   // fetch side
   input  logic                i_fetch,
   input  logic [WB_ADR_W-1:0] i_pc,
   output logic [WB_DAT_W-1:0] o_insn,
   output logic                o_insn_valid
);

   wb_req_t dbus_req;
   wb_rsp_t dbus_rsp;
   wb_req_t ibus_req;
   wb_rsp_t ibus_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;

   assign o_ls_done = dbus_rsp.ack;

   serial_lsu u_lsu (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_en        (i_en),
      .i_init      (i_init),
      .i_dat_valid (i_dat_valid),
      .i_cmd       (i_cmd),
      .i_funct3    (i_funct3),
      .i_rs1       (i_rs1),
      .i_rs2       (i_rs2),
      .i_imm       (i_imm),
      .i_trap      (i_trap),
      .o_rd        (o_rd),
      .o_misalign  (o_misalign),
      .o_dbus_req  (dbus_req),
      .i_dbus_rsp  (dbus_rsp)
   );

   insn_fetch u_fetch (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_fetch      (i_fetch),
      .i_pc         (i_pc),
      .o_insn       (o_insn),
      .o_insn_valid (o_insn_valid),
      .o_ibus_req   (ibus_req),
      .i_ibus_rsp   (ibus_rsp)
   );

   wb_arbiter u_arb (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_dbus_req (dbus_req),
      .o_dbus_rsp (dbus_rsp),
      .i_ibus_req (ibus_req),
      .o_ibus_rsp (ibus_rsp),
      .o_mem_req  (mem_req),
      .i_mem_rsp  (mem_rsp)
   );

   wb_ram u_ram (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_req   (mem_req),
      .o_rsp   (mem_rsp)
   );

endmodule

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
   import wb_pkg::*;
   import lsu_pkg::*;
();

   localparam int N_OPS         = 72;    // upper bound on bus operations in the run
   localparam int CYCLES_PER_OP = 200;
   localparam int ACK_WAIT      = 50;

   logic        clk;
   logic        reset;
   logic        en;
   logic        init;
   logic        dat_valid;
   logic        cmd;
   mem_width_e  funct3;
   logic        rs1;
   logic        rs2;
   logic        imm;
   logic        trap;
   logic        rd;
   logic        misalign;
   logic        ls_done;
   logic        fetch;
   logic [31:0] pc;
   logic [31:0] insn;
   logic        insn_valid;

   logic [31:0] rng;
   logic [31:0] ref_mem [RAM_WORDS];   // expected RAM contents
   logic        trap_window;           // no data ack may arrive while set
   int          word_idx [4];

   mem_subsystem_top dut0 (
      .i_clk        (clk),
      .i_reset      (reset),
      .i_en         (en),
      .i_init       (init),
      .i_dat_valid  (dat_valid),
      .i_cmd        (cmd),
      .i_funct3     (funct3),
      .i_rs1        (rs1),
      .i_rs2        (rs2),
      .i_imm        (imm),
      .i_trap       (trap),
      .o_rd         (rd),
      .o_misalign   (misalign),
      .o_ls_done    (ls_done),
      .i_fetch      (fetch),
      .i_pc         (pc),
      .o_insn       (insn),
      .o_insn_valid (insn_valid)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int width_bits(input mem_width_e f);
      if (f == MW_LW)
         return 32;
      else if (f == MW_LH || f == MW_LHU)
         return 16;
      return 8;
   endfunction

   // load result as the core should see it, from the expected word
   function automatic logic [31:0] expect_load(input mem_width_e f, input logic [31:0] word,
                                               input logic [1:0] off);
      logic [31:0] sh;
      sh = word >> (8 * off);
      case (f)
         MW_LB:   return {{24{sh[7]}}, sh[7:0]};
         MW_LBU:  return {24'h0, sh[7:0]};
         MW_LH:   return {{16{sh[15]}}, sh[15:0]};
         MW_LHU:  return {16'h0, sh[15:0]};
         default: return sh;
      endcase
   endfunction

   // ------------------------------------------------------------
   // serial port tasks
   // ------------------------------------------------------------

   // rs1 and imm are split randomly so the serial adder sees real carries
   task automatic run_init(input logic is_store, input mem_width_e f, input logic [31:0] addr,
                           input logic [31:0] data, input logic with_trap);
      logic [31:0] imm_val;
      logic [31:0] rs1_val;
      logic        exp_mis;
      rng     = xorshift32(rng);
      imm_val = rng;
      rs1_val = addr - imm_val;
      exp_mis = ((f == MW_LH || f == MW_LHU) && addr[0]) ||
                (f == MW_LW && addr[1:0] != 2'b00);
      for (int i = 0; i < XLEN; i++) begin
         @(negedge clk);
         en     = 1'b1;
         init   = 1'b1;
         cmd    = is_store;
         funct3 = f;
         rs1    = rs1_val[i];
         imm    = imm_val[i];
         rs2    = data[i];
      end
      @(negedge clk);
      assert (misalign == exp_mis) else value_mismatch("o_misalign", misalign, exp_mis);
      init = 1'b0;
      en   = 1'b0;   // the store data must not shift once init is over
      rs1  = 1'b0;
      imm  = 1'b0;
      rs2  = 1'b0;
      trap = with_trap;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ls_done && n < ACK_WAIT);
      if (!ls_done)
         abort_run("no o_ls_done arrived after the end of the init phase");
   endtask

   task automatic store_op(input mem_width_e f, input logic [31:0] addr,
                           input logic [31:0] data);
      int       idx;
      int       off;
      run_init(1'b1, f, addr, data, 1'b0);
      wait_done();
      idx = addr[RAM_AW+1:2];
      off = addr[1:0];
      case (f)
         MW_LW:   ref_mem[idx] = data;
         MW_LH:   ref_mem[idx][8*off +: 16] = data[15:0];
         default: ref_mem[idx][8*off +: 8] = data[7:0];
      endcase
   endtask

   task automatic load_op(input mem_width_e f, input logic [31:0] addr);
      logic [31:0] got;
      logic [31:0] exp;
      int          nvalid;
      run_init(1'b0, f, addr, 32'h0, 1'b0);
      wait_done();
      nvalid = width_bits(f);
      for (int i = 0; i < XLEN; i++) begin
         @(negedge clk);
         en        = 1'b1;
         dat_valid = (i < nvalid);
         #1;
         got[i] = rd;
      end
      @(negedge clk);
      en        = 1'b0;
      dat_valid = 1'b0;
      exp = expect_load(f, ref_mem[addr[RAM_AW+1:2]], addr[1:0]);
      assert (got == exp) else value_mismatch("o_rd", got, exp);
   endtask

   // misaligned access that the core traps, memory must stay as it is
   task automatic trapped_op(input logic is_store, input mem_width_e f,
                             input logic [31:0] addr, input logic [31:0] data);
      trap_window = 1'b1;
      run_init(is_store, f, addr, data, 1'b1);
      repeat (8) @(negedge clk);
      trap        = 1'b0;
      trap_window = 1'b0;
   endtask

   task automatic fetch_op(input int idx);
      int n;
      @(negedge clk);
      fetch = 1'b1;
      pc    = 32'(idx) << 2;
      @(negedge clk);
      fetch = 1'b0;
      n = 0;
      while (!insn_valid && n < ACK_WAIT) begin
         @(negedge clk);
         n++;
      end
      if (!insn_valid)
         abort_run("no o_insn_valid arrived after the fetch strobe");
      else
         assert (insn == ref_mem[idx]) else value_mismatch("o_insn", insn, ref_mem[idx]);
   endtask

   // ------------------------------------------------------------
   // protocol checks
   // ------------------------------------------------------------
   ap_done_pulse: assert property (@(posedge clk) disable iff (reset) ls_done |=> !ls_done)
      else abort_run("o_ls_done stayed high for more than one cycle");

   ap_valid_pulse: assert property (@(posedge clk) disable iff (reset)
      insn_valid |=> !insn_valid)
      else abort_run("o_insn_valid stayed high for more than one cycle");

   ap_no_done_on_trap: assert property (@(posedge clk) disable iff (reset)
      trap_window |-> !ls_done)
      else abort_run("a trapped access still completed a bus cycle");

   initial begin
      repeat (N_OPS * CYCLES_PER_OP) @(posedge clk);
      abort_run($sformatf("watchdog expired after %0d cycles", N_OPS * CYCLES_PER_OP));
   end

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial begin
      logic [31:0] data;
      int          w;
      reset       = 1'b1;
      en          = 1'b0;
      init        = 1'b0;
      dat_valid   = 1'b0;
      cmd         = 1'b0;
      funct3      = MW_LW;
      rs1         = 1'b0;
      rs2         = 1'b0;
      imm         = 1'b0;
      trap        = 1'b0;
      fetch       = 1'b0;
      pc          = 32'h0;
      trap_window = 1'b0;
      rng         = 32'hbcd1_f028;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // four distinct words, the low index bits keep them apart
      for (int k = 0; k < 4; k++) begin
         rng = xorshift32(rng);
         word_idx[k] = {rng[7:2], 2'(k)};
      end

      // word round trip
      for (int k = 0; k < 4; k++) begin
         rng = xorshift32(rng);
         store_op(MW_LW, 32'(word_idx[k]) << 2, rng);
      end
      for (int k = 0; k < 4; k++)
         load_op(MW_LW, 32'(word_idx[k]) << 2);

      // byte and half stores at every legal offset, each one read back as a word
      for (int k = 0; k < 2; k++) begin
         w = word_idx[k];
         for (int off = 0; off < 4; off++) begin
            rng = xorshift32(rng);
            store_op(MW_LB, (32'(w) << 2) + 32'(off), rng);
            load_op(MW_LW, 32'(w) << 2);
         end
         for (int off = 0; off < 4; off += 2) begin
            rng = xorshift32(rng);
            store_op(MW_LH, (32'(w) << 2) + 32'(off), rng);
            load_op(MW_LW, 32'(w) << 2);
         end
      end

      // sign and zero extension, one word with every sign bit set and one with none
      for (int k = 2; k < 4; k++) begin
         w = word_idx[k];
         rng  = xorshift32(rng);
         data = (k == 2) ? (rng | 32'h8080_8080) : (rng & 32'h7f7f_7f7f);
         store_op(MW_LW, 32'(w) << 2, data);
         for (int off = 0; off < 4; off++) begin
            load_op(MW_LB, (32'(w) << 2) + 32'(off));
            load_op(MW_LBU, (32'(w) << 2) + 32'(off));
         end
         for (int off = 0; off < 4; off += 2) begin
            load_op(MW_LH, (32'(w) << 2) + 32'(off));
            load_op(MW_LHU, (32'(w) << 2) + 32'(off));
         end
      end

      // misaligned accesses under trap
      w = word_idx[0];
      trapped_op(1'b1, MW_LH, (32'(w) << 2) + 32'd1, 32'hdead_beef);
      trapped_op(1'b1, MW_LW, (32'(w) << 2) + 32'd2, 32'h1234_5678);
      trapped_op(1'b0, MW_LW, (32'(w) << 2) + 32'd3, 32'h0);
      load_op(MW_LW, 32'(w) << 2);

      for (int k = 0; k < 4; k++)
         fetch_op(word_idx[k]);

      // fetch strobe lands on the last init step so the load's bus cycle waits behind it
      fork
         load_op(MW_LW, 32'(word_idx[1]) << 2);
         begin
            repeat (31) @(negedge clk);
            fetch_op(word_idx[2]);
         end
      join

      repeat (4) @(negedge clk);
      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- verilog.f
design/wb_pkg.sv
design/lsu_pkg.sv
design/serial_lsu.sv
design/insn_fetch.sv
design/wb_arbiter.sv
design/wb_ram.sv
design/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_mem_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
